//--- filelist.f
hdl/cnn_layer_pkg.sv
hdl/glb_map_pkg.sv
hdl/ifmap_addr_gen.sv
hdl/psum_addr_gen.sv
hdl/fifo_init_ctrl.sv
test/tb_fifo_init_ctrl.sv

//--- hdl/cnn_layer_pkg.sv
// CNN layer configuration types
// layer shape and tile position seen by the GLB front end

package cnn_layer_pkg;

    // pixel dimensions (tile width, real output width)
    localparam int DIM_W = 32;
    // channel count field
    localparam int CH_W  = 8;
    // output row counter inside a tile
    localparam int ROW_W = 32;

    // layer opcode as issued by the tile scheduler
    typedef enum logic [1:0] {
        POINTWISE = 2'd0,
        DEPTHWISE = 2'd1,
        STANDARD  = 2'd2,
        LINEAR    = 2'd3
    } layer_type_e;

    // static per-layer settings
    typedef struct packed {
        layer_type_e            layer_type;
        // tile width in pixels
        logic [DIM_W-1:0]       tile_n;
        // input channels
        logic [CH_W-1:0]        in_c;
        // real output width
        logic [DIM_W-1:0]       on_real;
    } layer_cfg_t;

    // where the current row sits
    typedef struct packed {
        // output row within the tile
        logic [ROW_W-1:0]       row_cnt;
        // tile touches the top border, needs top padding
        logic                   first_tile;
    } tile_pos_t;

endpackage

//--- hdl/fifo_init_ctrl.sv
// FIFO init control for the GLB front end
// resets the FIFO groups and loads their base addresses

`timescale 1ns/1ns

module fifo_init_ctrl
    import cnn_layer_pkg::*;
    import glb_map_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       init_i,
    input  layer_cfg_t cfg_i,
    input  tile_pos_t  pos_i,
    input  glb_base_t  base_i,
    input  logic       is_bias_i,
    output fifo_addr_t ifmap_addr_o,
    output fifo_addr_t ipsum_addr_o,
    output fifo_addr_t opsum_addr_o,
    output logic       ifmap_fifo_rst_o,
    output logic       ipsum_fifo_rst_o,
    output logic       opsum_fifo_rst_o
);

    addr_t ipsum_base;

    // all FIFOs stay in reset for the whole init window
    assign ifmap_fifo_rst_o = init_i;
    assign ipsum_fifo_rst_o = init_i;
    assign opsum_fifo_rst_o = init_i;

    // first pass of a layer reads bias instead of partial sums
    assign ipsum_base = is_bias_i ? base_i.bias : base_i.ipsum;

    ifmap_addr_gen u_ifmap_addr_gen (
        .clk    (clk),
        .rst_n  (rst_n),
        .init_i (init_i),
        .cfg_i  (cfg_i),
        .pos_i  (pos_i),
        .base_i (base_i.ifmap),
        .addr_o (ifmap_addr_o)
    );

    psum_addr_gen #(
        .OUT_STRIDE (1'b0)
    ) u_ipsum_addr_gen (
        .clk    (clk),
        .rst_n  (rst_n),
        .init_i (init_i),
        .cfg_i  (cfg_i),
        .base_i (ipsum_base),
        .addr_o (ipsum_addr_o)
    );

    // opsum channels are laid out at the real output width
    psum_addr_gen #(
        .OUT_STRIDE (1'b1)
    ) u_opsum_addr_gen (
        .clk    (clk),
        .rst_n  (rst_n),
        .init_i (init_i),
        .cfg_i  (cfg_i),
        .base_i (base_i.opsum),
        .addr_o (opsum_addr_o)
    );

endmodule

//--- hdl/glb_map_pkg.sv
// Global buffer address map
// FIFO group sizes and base address types

package glb_map_pkg;

    localparam int ADDR_W = 32;

    typedef logic [ADDR_W-1:0] addr_t;

    // FIFOs in each of the ifmap, ipsum and opsum groups
    localparam int NUM_FIFO = 32;

    // depthwise mapping: ten channels of three row FIFOs
    localparam int DW_CHANNELS = 10;
    localparam int DW_ROWS     = 3;

    // bytes per partial sum
    localparam int PSUM_BYTES = 2;

    // reserved region that reads back as zeros, used for top padding
    localparam addr_t ZERO_ZONE = 32'h8000_0000;

    // region bases handed down by the layer configuration
    typedef struct packed {
        addr_t ifmap;
        addr_t ipsum;
        addr_t opsum;
        addr_t bias;
    } glb_base_t;

    // one base address per FIFO of a group
    typedef addr_t [NUM_FIFO-1:0] fifo_addr_t;

endpackage

//--- hdl/ifmap_addr_gen.sv
// Ifmap FIFO base address generator

`timescale 1ns/1ns

module ifmap_addr_gen
    import cnn_layer_pkg::*;
    import glb_map_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       init_i,
    input  layer_cfg_t cfg_i,
    input  tile_pos_t  pos_i,
    input  addr_t      base_i,
    output fifo_addr_t addr_o
);

    logic       upd_en;
    logic       pad_top;
    logic       win_start;
    addr_t      in_c_w;
    addr_t      new_row_off;
    addr_t      ch_off [DW_CHANNELS];
    fifo_addr_t addr_d;

    assign upd_en = init_i &&
                    (cfg_i.layer_type == POINTWISE || cfg_i.layer_type == DEPTHWISE);

    // first tile starts one row late because row 0 is padding
    assign pad_top   = pos_i.first_tile && (pos_i.row_cnt == '0);
    assign win_start = pos_i.first_tile ? (pos_i.row_cnt == ROW_W'(1))
                                        : (pos_i.row_cnt == '0);

    assign in_c_w = addr_t'(cfg_i.in_c);

    // the row entering the window is one below the output row
    assign new_row_off = (pos_i.row_cnt + ROW_W'(1)) * in_c_w;

    // each depthwise channel owns a tile_n x in_c slab
    always_comb begin
        for (int c = 0; c < DW_CHANNELS; c++) begin
            ch_off[c] = addr_t'(c) * cfg_i.tile_n * in_c_w;
        end
    end

    always_comb begin
        addr_d = addr_o;
        case (cfg_i.layer_type)
            POINTWISE: begin
                // one FIFO per input channel
                for (int k = 0; k < NUM_FIFO; k++) begin
                    addr_d[k] = base_i + addr_t'(k) * cfg_i.tile_n;
                end
            end
            DEPTHWISE: begin
                // entries 30 and 31 are unused and keep their value
                for (int c = 0; c < DW_CHANNELS; c++) begin
                    for (int r = 0; r < DW_ROWS; r++) begin
                        if (win_start) begin
                            addr_d[c*DW_ROWS + r] = base_i + ch_off[c] + addr_t'(r) * in_c_w;
                        end else if (pad_top) begin
                            if (r == 0) begin
                                addr_d[c*DW_ROWS + r] = ZERO_ZONE;
                            end else begin
                                addr_d[c*DW_ROWS + r] = base_i + ch_off[c]
                                                      + addr_t'(r - 1) * in_c_w;
                            end
                        end else if (r < DW_ROWS - 1) begin
                            // slide the window up by one row
                            addr_d[c*DW_ROWS + r] = addr_o[c*DW_ROWS + r + 1];
                        end else begin
                            addr_d[c*DW_ROWS + r] = base_i + ch_off[c] + new_row_off;
                        end
                    end
                end
            end
            default: begin
                // standard and linear layers leave the map alone
                addr_d = addr_o;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_o <= '0;
        end else if (upd_en) begin
            addr_o <= addr_d;
        end
    end

endmodule

//--- hdl/psum_addr_gen.sv
// Partial sum FIFO base address generator

`timescale 1ns/1ns

module psum_addr_gen
    import cnn_layer_pkg::*;
    import glb_map_pkg::*;
#(
    // 0 strides channels by tile width, 1 by real output width
    parameter bit OUT_STRIDE = 1'b0
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       init_i,
    input  layer_cfg_t cfg_i,
    input  addr_t      base_i,
    output fifo_addr_t addr_o
);

    logic       upd_en;
    addr_t      in_c_w;
    addr_t      ch_stride;
    addr_t      pw_stride;
    fifo_addr_t addr_d;

    assign upd_en = init_i &&
                    (cfg_i.layer_type == POINTWISE || cfg_i.layer_type == DEPTHWISE);

    assign in_c_w = addr_t'(cfg_i.in_c);

    // depthwise channel slab size
    assign ch_stride = OUT_STRIDE ? cfg_i.on_real * in_c_w
                                  : cfg_i.tile_n * in_c_w;

    // pointwise: one output row of psums per FIFO
    assign pw_stride = cfg_i.on_real * addr_t'(PSUM_BYTES);

    always_comb begin
        addr_d = addr_o;
        case (cfg_i.layer_type)
            POINTWISE: begin
                for (int k = 0; k < NUM_FIFO; k++) begin
                    addr_d[k] = base_i + addr_t'(k) * pw_stride;
                end
            end
            DEPTHWISE: begin
                // three rows per channel, top two FIFOs untouched
                for (int c = 0; c < DW_CHANNELS; c++) begin
                    for (int r = 0; r < DW_ROWS; r++) begin
                        addr_d[c*DW_ROWS + r] = base_i + addr_t'(c) * ch_stride
                                              + addr_t'(r) * in_c_w;
                    end
                end
            end
            default: begin
                addr_d = addr_o;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_o <= '0;
        end else if (upd_en) begin
            addr_o <= addr_d;
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_fifo_init_ctrl -f filelist.f \
    -o sim_fifo_init_ctrl \
    && ./obj_dir/sim_fifo_init_ctrl \
    || exit 1

//--- test/tb_fifo_init_ctrl.sv
// Directed testbench for the FIFO init controller

`timescale 1ns/1ns

module tb_fifo_init_ctrl
    import cnn_layer_pkg::*;
    import glb_map_pkg::*;
();

    localparam int CLK_PERIOD     = 10;
    localparam int RESET_CYCLES   = 8;
    // about 20 init and hold cycles after reset, so this leaves a wide margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic       clk;
    logic       rst_n;
    logic       init_i;
    layer_cfg_t cfg_i;
    tile_pos_t  pos_i;
    glb_base_t  base_i;
    logic       is_bias_i;
    fifo_addr_t ifmap_addr_o;
    fifo_addr_t ipsum_addr_o;
    fifo_addr_t opsum_addr_o;
    logic       ifmap_fifo_rst_o;
    logic       ipsum_fifo_rst_o;
    logic       opsum_fifo_rst_o;

    // reference copies of the three address maps
    fifo_addr_t exp_ifmap;
    fifo_addr_t exp_ipsum;
    fifo_addr_t exp_opsum;

    int          cycle_cnt;
    int unsigned seed_ret;
    layer_cfg_t  dw_cfg;
    glb_base_t   dw_base;

    fifo_init_ctrl u_fifo_init_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .init_i           (init_i),
        .cfg_i            (cfg_i),
        .pos_i            (pos_i),
        .base_i           (base_i),
        .is_bias_i        (is_bias_i),
        .ifmap_addr_o     (ifmap_addr_o),
        .ipsum_addr_o     (ipsum_addr_o),
        .opsum_addr_o     (opsum_addr_o),
        .ifmap_fifo_rst_o (ifmap_fifo_rst_o),
        .ipsum_fifo_rst_o (ipsum_fifo_rst_o),
        .opsum_fifo_rst_o (opsum_fifo_rst_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_on_failure();
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_addr(input string name, input fifo_addr_t exp, input fifo_addr_t act);
        int bad;
        bad = -1;
        for (int k = NUM_FIFO - 1; k >= 0; k--) begin
            if (act[k] !== exp[k]) begin
                bad = k;
            end
        end
        if (bad >= 0) begin
            $display("ERR %s entry %0d expected %h actual %h", name, bad, exp[bad], act[bad]);
            stop_on_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic compare_groups(input string name);
        check_addr({name, " ifmap"}, exp_ifmap, ifmap_addr_o);
        check_addr({name, " ipsum"}, exp_ipsum, ipsum_addr_o);
        check_addr({name, " opsum"}, exp_opsum, opsum_addr_o);
    endtask

    task automatic check_resets(input string name, input logic exp);
        check_bit({name, " ifmap rst"}, exp, ifmap_fifo_rst_o);
        check_bit({name, " ipsum rst"}, exp, ipsum_fifo_rst_o);
        check_bit({name, " opsum rst"}, exp, opsum_fifo_rst_o);
    endtask

    function automatic layer_cfg_t random_cfg(input layer_type_e t);
        layer_cfg_t cfg;
        cfg.layer_type = t;
        // disjoint ranges keep the two psum strides apart
        cfg.tile_n     = $urandom_range(127, 8);
        cfg.on_real    = $urandom_range(511, 128);
        cfg.in_c       = CH_W'($urandom_range(255, 1));
        return cfg;
    endfunction

    function automatic glb_base_t random_base();
        glb_base_t base;
        // word aligned and below the zero zone
        base.ifmap = $urandom & 32'h3fff_fff0;
        base.ipsum = $urandom & 32'h3fff_fff0;
        base.opsum = $urandom & 32'h3fff_fff0;
        base.bias  = $urandom & 32'h3fff_fff0;
        return base;
    endfunction

    function automatic tile_pos_t make_pos(input logic first, input int row);
        tile_pos_t pos;
        pos.row_cnt    = ROW_W'(row);
        pos.first_tile = first;
        return pos;
    endfunction

    // reference model of one update edge
    task automatic model_step(input layer_cfg_t cfg, input tile_pos_t pos,
                              input glb_base_t base, input logic bias);
        fifo_addr_t prev;
        addr_t      ps_base;
        addr_t      in_c;
        addr_t      ifm_slab;
        int         e;
        prev    = exp_ifmap;
        ps_base = bias ? base.bias : base.ipsum;
        in_c    = addr_t'(cfg.in_c);
        if (cfg.layer_type == POINTWISE) begin
            for (int k = 0; k < NUM_FIFO; k++) begin
                exp_ifmap[k] = base.ifmap + addr_t'(k) * cfg.tile_n;
                exp_ipsum[k] = ps_base + addr_t'(k) * cfg.on_real * addr_t'(PSUM_BYTES);
                exp_opsum[k] = base.opsum + addr_t'(k) * cfg.on_real * addr_t'(PSUM_BYTES);
            end
        end else if (cfg.layer_type == DEPTHWISE) begin
            for (int c = 0; c < DW_CHANNELS; c++) begin
                e        = c * DW_ROWS;
                ifm_slab = base.ifmap + addr_t'(c) * cfg.tile_n * in_c;
                if (pos.first_tile && pos.row_cnt == '0) begin
                    exp_ifmap[e]     = ZERO_ZONE;
                    exp_ifmap[e + 1] = ifm_slab;
                    exp_ifmap[e + 2] = ifm_slab + in_c;
                end else if (pos.row_cnt == ROW_W'(pos.first_tile)) begin
                    // window start loads all three rows
                    exp_ifmap[e]     = ifm_slab;
                    exp_ifmap[e + 1] = ifm_slab + in_c;
                    exp_ifmap[e + 2] = ifm_slab + addr_t'(2) * in_c;
                end else begin
                    exp_ifmap[e]     = prev[e + 1];
                    exp_ifmap[e + 1] = prev[e + 2];
                    exp_ifmap[e + 2] = ifm_slab + (pos.row_cnt + 32'd1) * in_c;
                end
                for (int r = 0; r < DW_ROWS; r++) begin
                    exp_ipsum[e + r] = ps_base + addr_t'(c) * cfg.tile_n * in_c
                                     + addr_t'(r) * in_c;
                    exp_opsum[e + r] = base.opsum + addr_t'(c) * cfg.on_real * in_c
                                     + addr_t'(r) * in_c;
                end
            end
        end
    endtask

    // one init cycle, entered and left on a falling edge
    task automatic init_cycle(input string name, input layer_cfg_t cfg, input tile_pos_t pos,
                              input glb_base_t base, input logic bias);
        init_i    = 1'b1;
        cfg_i     = cfg;
        pos_i     = pos;
        base_i    = base;
        is_bias_i = bias;
        // resets must rise before any clock edge
        #1;
        check_resets({name, " before edge"}, 1'b1);
        @(negedge clk);
        model_step(cfg, pos, base, bias);
        check_resets(name, 1'b1);
        compare_groups(name);
        init_i = 1'b0;
    endtask

    task automatic reset_state_test();
        compare_groups("after reset");
        check_resets("after reset", 1'b0);
        init_cycle("reset linear", random_cfg(LINEAR), make_pos(1'b0, 0), random_base(), 1'b0);
        #1;
        check_resets("init dropped", 1'b0);
        @(negedge clk);
    endtask

    task automatic pointwise_load();
        init_cycle("pointwise", random_cfg(POINTWISE), make_pos(1'b0, 0), random_base(), 1'b0);
        init_cycle("pointwise bias", random_cfg(POINTWISE), make_pos(1'b0, 0),
                   random_base(), 1'b1);
    endtask

    task automatic depthwise_first_tile();
        dw_cfg  = random_cfg(DEPTHWISE);
        dw_base = random_base();
        init_cycle("dw top pad", dw_cfg, make_pos(1'b1, 0), dw_base, 1'b0);
        init_cycle("dw first window", dw_cfg, make_pos(1'b1, 1), dw_base, 1'b0);
    endtask

    task automatic window_slide();
        init_cycle("dw slide row 2", dw_cfg, make_pos(1'b1, 2), dw_base, 1'b0);
        // new base only reaches the entering row, shifted rows keep the old one
        dw_base = random_base();
        init_cycle("dw slide row 3", dw_cfg, make_pos(1'b1, 3), dw_base, 1'b0);
        // next tile down starts a fresh window at row 0
        dw_base = random_base();
        init_cycle("dw tile start", dw_cfg, make_pos(1'b0, 0), dw_base, 1'b0);
        init_cycle("dw tile row 1", dw_cfg, make_pos(1'b0, 1), dw_base, 1'b0);
        dw_base = random_base();
        init_cycle("dw tile row 2", dw_cfg, make_pos(1'b0, 2), dw_base, 1'b0);
    endtask

    task automatic depthwise_psum_strides();
        init_cycle("psum pw fill", random_cfg(POINTWISE), make_pos(1'b0, 0),
                   random_base(), 1'b0);
        // entries 30 and 31 must keep the pointwise values
        init_cycle("psum dw", random_cfg(DEPTHWISE), make_pos(1'b0, 0), random_base(), 1'b1);
    endtask

    task automatic hold_when_idle();
        init_i    = 1'b0;
        cfg_i     = random_cfg(DEPTHWISE);
        pos_i     = make_pos(1'b0, 5);
        base_i    = random_base();
        is_bias_i = 1'b1;
        repeat (3) @(negedge clk);
        check_resets("hold init low", 1'b0);
        compare_groups("hold init low");
        init_cycle("hold standard", random_cfg(STANDARD), make_pos(1'b0, 4), random_base(), 1'b0);
        init_cycle("hold linear", random_cfg(LINEAR), make_pos(1'b1, 0), random_base(), 1'b1);
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        stop_on_failure();
    end

    initial begin
        seed_ret  = $urandom(32'had96);
        rst_n     = 1'b0;
        init_i    = 1'b0;
        cfg_i     = '0;
        pos_i     = '0;
        base_i    = '0;
        is_bias_i = 1'b0;
        exp_ifmap = '0;
        exp_ipsum = '0;
        exp_opsum = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        reset_state_test();
        pointwise_load();
        depthwise_first_tile();
        window_slide();
        depthwise_psum_strides();
        hold_when_idle();
        $display("All tests passed!");
        $finish;
    end

endmodule
